// File: hdl/rx_pkg.sv
// package with command opcodes, oscillator table and shared width constants
package rx_pkg;

	// signed ADC sample width
	localparam int ADC_BITS = 14;

	// width of a buffered word and of each I or Q output
	localparam int SAMP_BITS = 16;

	// phase accumulator and tuning word width
	localparam int FREQ_BITS = 32;

	// top phase bits that address the oscillator table
	localparam int LUT_BITS = 4;

	// width of one signed table entry
	localparam int LUT_W = 12;

	// products are scaled down by this arithmetic shift before they are summed
	localparam int MIX_SHIFT = 11;

	// width of the programmed sample-set count
	localparam int NSAMPS_BITS = 7;

	// command port opcodes, value 3 is unused
	localparam logic [1:0] OP_SET_CHAN   = 2'd0;
	localparam logic [1:0] OP_SET_FREQ   = 2'd1;
	localparam logic [1:0] OP_SET_NSAMPS = 2'd2;

	// one full cosine cycle in sixteen steps, full scale 2047
	// entry k+4 is cos(x + pi/2) which is the negative sine used for Q
	localparam logic signed [LUT_W-1:0] COS_LUT [0:2**LUT_BITS-1] = '{
		12'sd2047,  12'sd1891,  12'sd1447,  12'sd783,
		12'sd0,    -12'sd783,  -12'sd1447, -12'sd1891,
		-12'sd2047, -12'sd1891, -12'sd1447, -12'sd783,
		12'sd0,     12'sd783,   12'sd1447,  12'sd1891
	};

endpackage

// File: hdl/rx_cmd_regs.sv
// host command decoder with channel select, sample-set count and service-request flag
`timescale 1ns/1ps

module rx_cmd_regs #(
	parameter int RX_CHANS = 4
) (
	input  logic                               cpu_clk,
	input  logic                               rst_i,
	input  logic                               cmd_wr_i,
	input  logic [1:0]                         cmd_op_i,
	input  logic [rx_pkg::FREQ_BITS-1:0]       cmd_data_i,
	input  logic                               swap_i,
	input  logic                               srq_ack_i,
	output logic [RX_CHANS-1:0]                freq_wr_o,
	output logic [rx_pkg::FREQ_BITS-1:0]       freq_word_o,
	output logic [rx_pkg::NSAMPS_BITS-1:0]     nsamps_o,
	output logic                               srq_o
);

	// a single channel still needs a one bit select register
	localparam int CHAN_W = (RX_CHANS > 1) ? $clog2(RX_CHANS) : 1;

	logic [CHAN_W-1:0]   chan_sel;
	logic                set_chan;
	logic                set_freq;
	logic                set_nsamps;
	logic [RX_CHANS-1:0] chan_onehot;

	// every strobed command is taken in its own cycle, there is no busy state
	assign set_chan   = cmd_wr_i && (cmd_op_i == rx_pkg::OP_SET_CHAN);
	assign set_freq   = cmd_wr_i && (cmd_op_i == rx_pkg::OP_SET_FREQ);
	assign set_nsamps = cmd_wr_i && (cmd_op_i == rx_pkg::OP_SET_NSAMPS);

	// the stored channel index picks which channel sees the frequency write
	assign chan_onehot = RX_CHANS'(1) << chan_sel;

	// the write pulse is combinational so the channel loads on the strobe edge
	assign freq_wr_o = set_freq ? chan_onehot : '0;

	// the tuning word goes to all channels, only the pulsed one takes it
	assign freq_word_o = cmd_data_i;

	always_ff @(posedge cpu_clk)
	begin
		if (rst_i)
		begin
			chan_sel <= '0;
			nsamps_o <= '0;
		end
		else
		begin
			// low bits of the data word carry the channel index
			if (set_chan)
			begin
				chan_sel <= cmd_data_i[CHAN_W-1:0];
			end
			// a set is counted from zero so the swap comes every nsamps + 1 sets
			if (set_nsamps)
			begin
				nsamps_o <= cmd_data_i[rx_pkg::NSAMPS_BITS-1:0];
			end
		end
	end

	// service request follows a bank swap by one cycle and holds until the host acks
	// a swap in the same cycle as an ack leaves the flag set, since a new bank is ready
	always_ff @(posedge cpu_clk)
	begin
		if (rst_i)
		begin
			srq_o <= 1'b0;
		end
		else if (swap_i)
		begin
			srq_o <= 1'b1;
		end
		else if (srq_ack_i)
		begin
			srq_o <= 1'b0;
		end
	end

endmodule

// File: hdl/rx_ddc_chan.sv
// one down-converter channel with phase accumulator, table mixer and decimating integrator
`timescale 1ns/1ps

module rx_ddc_chan #(
	parameter int DECIM = 16
) (
	input  logic                                cpu_clk,
	input  logic                                rst_i,
	input  logic signed [rx_pkg::ADC_BITS-1:0]  adc_data_i,
	input  logic                                freq_wr_i,
	input  logic [rx_pkg::FREQ_BITS-1:0]        freq_word_i,
	input  logic                                rd_q_i,
	output logic                                avail_o,
	output logic [rx_pkg::SAMP_BITS-1:0]        dout_o
);

	// full product width, the shifted value is kept at this width too
	localparam int PROD_W = rx_pkg::ADC_BITS + rx_pkg::LUT_W;
	// room for DECIM products without overflow
	localparam int ACC_W  = PROD_W + $clog2(DECIM);
	localparam int CNT_W  = $clog2(DECIM);
	// a quarter cycle in table steps turns cosine into negative sine
	localparam logic [rx_pkg::LUT_BITS-1:0] QTR = rx_pkg::LUT_BITS'(2**(rx_pkg::LUT_BITS-2));

	logic [rx_pkg::FREQ_BITS-1:0] phase;
	logic [rx_pkg::FREQ_BITS-1:0] tune;
	logic [rx_pkg::LUT_BITS-1:0]  idx_i;
	logic [rx_pkg::LUT_BITS-1:0]  idx_q;
	logic signed [rx_pkg::LUT_W-1:0] cos_i;
	logic signed [rx_pkg::LUT_W-1:0] cos_q;
	logic signed [PROD_W-1:0]     prod_i;
	logic signed [PROD_W-1:0]     prod_q;
	logic signed [ACC_W-1:0]      acc_i;
	logic signed [ACC_W-1:0]      acc_q;
	logic signed [ACC_W-1:0]      sum_i;
	logic signed [ACC_W-1:0]      sum_q;
	logic [CNT_W-1:0]             cnt;
	logic                         dump;
	logic [rx_pkg::SAMP_BITS-1:0] i_word;
	logic [rx_pkg::SAMP_BITS-1:0] q_word;

	// the table is addressed by the top phase bits
	assign idx_i = phase[rx_pkg::FREQ_BITS-1 -: rx_pkg::LUT_BITS];
	assign idx_q = idx_i + QTR;
	assign cos_i = rx_pkg::COS_LUT[idx_i];
	assign cos_q = rx_pkg::COS_LUT[idx_q];

	// mix and scale, the arithmetic shift keeps the sign
	assign prod_i = (adc_data_i * cos_i) >>> rx_pkg::MIX_SHIFT;
	assign prod_q = (adc_data_i * cos_q) >>> rx_pkg::MIX_SHIFT;

	// running sums including the sample on this edge
	assign sum_i = acc_i + prod_i;
	assign sum_q = acc_q + prod_q;

	// after reset the channel runs as if it had been written with tuning word zero
	// a frequency write restarts phase, sums and counter so the next sample is term one
	always_ff @(posedge cpu_clk)
	begin
		if (rst_i || freq_wr_i)
		begin
			phase <= '0;
			acc_i <= '0;
			acc_q <= '0;
			cnt   <= '0;
			dump  <= 1'b0;
		end
		else
		begin
			phase <= phase + tune;
			dump  <= (cnt == CNT_W'(DECIM - 1));
			if (cnt == CNT_W'(DECIM - 1))
			begin
				// last term of the set, start the next set from empty sums
				cnt   <= '0;
				acc_i <= '0;
				acc_q <= '0;
			end
			else
			begin
				cnt   <= cnt + 1'b1;
				acc_i <= sum_i;
				acc_q <= sum_q;
			end
		end
	end

	// tuning word register, cleared by reset
	always_ff @(posedge cpu_clk)
	begin
		if (rst_i)
		begin
			tune <= '0;
		end
		else if (freq_wr_i)
		begin
			tune <= freq_word_i;
		end
	end

	// finished sums are truncated to the buffer word width
	always_ff @(posedge cpu_clk)
	begin
		if (cnt == CNT_W'(DECIM - 1))
		begin
			i_word <= sum_i[rx_pkg::SAMP_BITS-1:0];
			q_word <= sum_q[rx_pkg::SAMP_BITS-1:0];
		end
	end

	// avail comes one cycle after the sums are registered, giving DECIM + 1 latency
	always_ff @(posedge cpu_clk)
	begin
		if (rst_i)
		begin
			avail_o <= 1'b0;
		end
		else
		begin
			avail_o <= dump;
		end
	end

	// the collector reads I first and then Q
	assign dout_o = rd_q_i ? q_word : i_word;

	// a set always spans several samples so avail can never be two cycles wide
	a_avail_single: assert property (@(posedge cpu_clk) disable iff (rst_i)
		avail_o |=> !avail_o);

endmodule

// File: hdl/rx_collector.sv
// transfer FSM that interleaves channel I/Q words into the buffer and counts sample sets
`timescale 1ns/1ps

module rx_collector #(
	parameter int RX_CHANS = 4
) (
	input  logic                                     cpu_clk,
	input  logic                                     rst_i,
	input  logic                                     avail_i,
	input  logic [RX_CHANS*rx_pkg::SAMP_BITS-1:0]    chan_dout_i,
	input  logic [rx_pkg::NSAMPS_BITS-1:0]           nsamps_i,
	output logic                                     rd_q_o,
	output logic                                     buf_wr_o,
	output logic [rx_pkg::SAMP_BITS-1:0]             buf_wdata_o,
	output logic                                     swap_o
);

	localparam int CHAN_W = (RX_CHANS > 1) ? $clog2(RX_CHANS) : 1;
	localparam logic [CHAN_W-1:0] LAST_CHAN = CHAN_W'(RX_CHANS - 1);

	logic                           busy;
	logic [CHAN_W-1:0]              chan;
	logic                           q_phase;
	logic                           last_word;
	logic [rx_pkg::NSAMPS_BITS-1:0] set_cnt;

	// the Q word of the highest channel ends the transfer
	assign last_word = q_phase && (chan == LAST_CHAN);

	// all channels share the I/Q select, the word is then picked by channel index
	assign rd_q_o      = q_phase;
	assign buf_wr_o    = busy;
	assign buf_wdata_o = chan_dout_i[chan*rx_pkg::SAMP_BITS +: rx_pkg::SAMP_BITS];

	// the transfer starts on the cycle after avail and writes one word per cycle
	// order is ch0 I, ch0 Q, ch1 I and so on
	always_ff @(posedge cpu_clk)
	begin
		if (rst_i)
		begin
			busy    <= 1'b0;
			chan    <= '0;
			q_phase <= 1'b0;
			set_cnt <= '0;
			swap_o  <= 1'b0;
		end
		else
		begin
			swap_o <= 1'b0;
			if (busy)
			begin
				q_phase <= ~q_phase;
				if (q_phase)
				begin
					chan <= chan + 1'b1;
				end
				if (last_word)
				begin
					busy <= 1'b0;
					chan <= '0;
					// one full set is in, swap once the programmed count is reached
					if (set_cnt == nsamps_i)
					begin
						swap_o  <= 1'b1;
						set_cnt <= '0;
					end
					else
					begin
						set_cnt <= set_cnt + 1'b1;
					end
				end
			end
			else if (avail_i)
			begin
				busy    <= 1'b1;
				chan    <= '0;
				q_phase <= 1'b0;
			end
		end
	end

	// DECIM must leave room for the whole interleave before the channels deliver again
	a_no_overrun: assert property (@(posedge cpu_clk) disable iff (rst_i)
		avail_i |=> (!avail_i) [* 2*RX_CHANS]);

endmodule

// File: hdl/rx_sample_buf.sv
// double-banked sample memory with write pointer, prefetching read pointer and bank toggle
`timescale 1ns/1ps

module rx_sample_buf #(
	parameter int BUF_AW = 7
) (
	input  logic                          cpu_clk,
	input  logic                          rst_i,
	input  logic                          wr_i,
	input  logic [rx_pkg::SAMP_BITS-1:0]  wdata_i,
	input  logic                          swap_i,
	input  logic                          rd_i,
	output logic [rx_pkg::SAMP_BITS-1:0]  rdata_o
);

	// bank bit on top of the word address
	logic [rx_pkg::SAMP_BITS-1:0] mem [0:2**(BUF_AW+1)-1];

	// bank is the half being written, the host reads the other one
	logic              bank;
	logic              rd_bank_nxt;
	logic [BUF_AW-1:0] waddr;
	logic [BUF_AW-1:0] raddr;
	logic [BUF_AW-1:0] raddr_nxt;

	// read address for the coming cycle so the output register is always current
	// after a swap the half just written becomes readable from word 0
	assign raddr_nxt   = swap_i ? '0 : raddr + {{(BUF_AW-1){1'b0}}, rd_i};
	assign rd_bank_nxt = swap_i ? bank : ~bank;

	always_ff @(posedge cpu_clk)
	begin
		if (rst_i)
		begin
			bank  <= 1'b0;
			waddr <= '0;
			raddr <= '0;
		end
		else
		begin
			raddr <= raddr_nxt;
			if (swap_i)
			begin
				bank  <= ~bank;
				waddr <= '0;
			end
			else if (wr_i)
			begin
				waddr <= waddr + 1'b1;
			end
		end
	end

	// write port and registered read, which infer a simple dual-port RAM
	always_ff @(posedge cpu_clk)
	begin
		if (wr_i)
		begin
			mem[{bank, waddr}] <= wdata_i;
		end
		rdata_o <= mem[{rd_bank_nxt, raddr_nxt}];
	end

	// a bank must be swapped before its write pointer runs past the last word
	a_no_wrap: assert property (@(posedge cpu_clk) disable iff (rst_i)
		(wr_i && !swap_i) |=> (waddr != '0));

endmodule

// File: hdl/rx_receiver.sv
// receiver top level with command registers, DDC channel array, collector and sample buffer
`timescale 1ns/1ps

module rx_receiver #(
	parameter int RX_CHANS = 4,
	parameter int DECIM    = 16,
	parameter int BUF_AW   = 7
) (
	input  logic                                cpu_clk,
	input  logic                                rst_i,
	input  logic signed [rx_pkg::ADC_BITS-1:0]  adc_data_i,
	input  logic                                cmd_wr_i,
	input  logic [1:0]                          cmd_op_i,
	input  logic [rx_pkg::FREQ_BITS-1:0]        cmd_data_i,
	input  logic                                rd_samp_i,
	input  logic                                srq_ack_i,
	output logic [rx_pkg::SAMP_BITS-1:0]        samp_o,
	output logic                                srq_o
);

	logic [RX_CHANS-1:0]                  freq_wr;
	logic [rx_pkg::FREQ_BITS-1:0]         freq_word;
	logic [rx_pkg::NSAMPS_BITS-1:0]       nsamps;
	// only channel 0 avail is used, all channels share one decimation rate
	logic [RX_CHANS-1:0]                  chan_avail;
	logic [RX_CHANS*rx_pkg::SAMP_BITS-1:0] chan_dout;
	logic                                 rd_q;
	logic                                 buf_wr;
	logic [rx_pkg::SAMP_BITS-1:0]         buf_wdata;
	logic                                 swap;

	rx_cmd_regs #(
		.RX_CHANS (RX_CHANS)
	) cmd_regs_i (
		.cpu_clk     (cpu_clk),
		.rst_i       (rst_i),
		.cmd_wr_i    (cmd_wr_i),
		.cmd_op_i    (cmd_op_i),
		.cmd_data_i  (cmd_data_i),
		.swap_i      (swap),
		.srq_ack_i   (srq_ack_i),
		.freq_wr_o   (freq_wr),
		.freq_word_o (freq_word),
		.nsamps_o    (nsamps),
		.srq_o       (srq_o)
	);

	// each channel gets its own write pulse but the shared tuning word and I/Q select
	for (genvar g = 0; g < RX_CHANS; g++)
	begin : g_chan
		rx_ddc_chan #(
			.DECIM (DECIM)
		) ddc_i (
			.cpu_clk     (cpu_clk),
			.rst_i       (rst_i),
			.adc_data_i  (adc_data_i),
			.freq_wr_i   (freq_wr[g]),
			.freq_word_i (freq_word),
			.rd_q_i      (rd_q),
			.avail_o     (chan_avail[g]),
			.dout_o      (chan_dout[g*rx_pkg::SAMP_BITS +: rx_pkg::SAMP_BITS])
		);
	end

	rx_collector #(
		.RX_CHANS (RX_CHANS)
	) collector_i (
		.cpu_clk     (cpu_clk),
		.rst_i       (rst_i),
		.avail_i     (chan_avail[0]),
		.chan_dout_i (chan_dout),
		.nsamps_i    (nsamps),
		.rd_q_o      (rd_q),
		.buf_wr_o    (buf_wr),
		.buf_wdata_o (buf_wdata),
		.swap_o      (swap)
	);

	rx_sample_buf #(
		.BUF_AW (BUF_AW)
	) sample_buf_i (
		.cpu_clk (cpu_clk),
		.rst_i   (rst_i),
		.wr_i    (buf_wr),
		.wdata_i (buf_wdata),
		.swap_i  (swap),
		.rd_i    (rd_samp_i),
		.rdata_o (samp_o)
	);

endmodule

// File: tests/rx_tb_model.svh
// reference model with the recorded ADC stimulus, oscillator lookup, mixer term and expected words
`ifndef RX_TB_MODEL_SVH
`define RX_TB_MODEL_SVH

// ADC value driven in each cycle of the current entry, indexed by the edge count at drive time
int adc_hist [0:HIST_LEN-1];

// oscillator coefficient for term n of a channel whose phase started at zero
// the Q path looks a quarter cycle ahead in the table, which gives the negative sine
function automatic int osc_coef(input logic [31:0] tune, input int n, input bit quad);
	logic [31:0] ph;
	int          top;
	int          idx;
	int          lut_len;
	lut_len = 2 ** rx_pkg::LUT_BITS;
	// the phase wraps at the accumulator width, so the product is kept at 32 bits
	ph  = tune * 32'(n);
	top = int'(ph >> (rx_pkg::FREQ_BITS - rx_pkg::LUT_BITS));
	idx = (top + (quad ? lut_len / 4 : 0)) % lut_len;
	return int'(rx_pkg::COS_LUT[idx]);
endfunction

// one mixed term, scaled down with an arithmetic shift so negative values round toward minus
function automatic int mix_term(input int sample, input int coef);
	int prod;
	prod = sample * coef;
	return prod >>> rx_pkg::MIX_SHIFT;
endfunction

// expected I or Q word of one sample set
// term 0 of the channel is the sample driven in the cycle of its frequency write edge
function automatic logic [15:0] expect_word(input int first_cyc, input logic [31:0] tune,
		input int set_idx, input bit quad);
	int sum;
	int n;
	int k;
	sum = 0;
	for (k = 0; k < TB_DECIM; k++)
	begin
		n   = set_idx * TB_DECIM + k;
		sum = sum + mix_term(adc_hist[first_cyc + n], osc_coef(tune, n, quad));
	end
	// the buffered word keeps only the low bits of the sum
	return sum[rx_pkg::SAMP_BITS-1:0];
endfunction

`endif

// File: tests/tb_rx_receiver.sv
// testbench for the receiver top level with stimulus table, model checks and watchdog
`timescale 1ns/1ps

module tb_rx_receiver;

	// these match the default parameters of the DUT
	localparam int TB_CHANS     = 4;
	localparam int TB_DECIM     = 16;
	localparam int RESET_CYCLES = 16;
	localparam int HIST_LEN     = 512;
	localparam int NUM_ENTRIES  = 5;

	// one table entry, tuning words are listed with the highest channel first
	typedef struct packed {
		logic [3:0][31:0]   tune;
		logic               rnd;
		logic signed [15:0] amp;
		logic [6:0]         nsamps;
		logic               chk;
		logic [15:0]        exp_i0;
		logic [15:0]        exp_q0;
	} stim_t;

	logic                               cpu_clk;
	logic                               rst_i;
	logic signed [rx_pkg::ADC_BITS-1:0] adc_data_i;
	logic                               cmd_wr_i;
	logic [1:0]                         cmd_op_i;
	logic [rx_pkg::FREQ_BITS-1:0]       cmd_data_i;
	logic                               rd_samp_i;
	logic                               srq_ack_i;
	logic [rx_pkg::SAMP_BITS-1:0]       samp_o;
	logic                               srq_o;

	stim_t  stim_tab [0:NUM_ENTRIES-1];
	integer seed;
	int     cyc;
	int     wr_edge [0:TB_CHANS-1];
	logic   cur_rnd;
	int     cur_amp;
	longint limit_ns;

	`include "rx_tb_model.svh"

	rx_receiver dut_i (
		.cpu_clk    (cpu_clk),
		.rst_i      (rst_i),
		.adc_data_i (adc_data_i),
		.cmd_wr_i   (cmd_wr_i),
		.cmd_op_i   (cmd_op_i),
		.cmd_data_i (cmd_data_i),
		.rd_samp_i  (rd_samp_i),
		.srq_ack_i  (srq_ack_i),
		.samp_o     (samp_o),
		.srq_o      (srq_o)
	);

	initial
	begin
		cpu_clk = 1'b0;
		forever #5 cpu_clk = ~cpu_clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	// drives every input for the coming edge, waits for it and returns 1 ns after it
	// outputs are read at that point, well away from the edge
	task automatic tick(input logic wr, input logic [1:0] op, input logic [31:0] data,
			input logic rd, input logic ack);
		int sample;
		if (cur_rnd)
		begin
			sample = $random(seed) % cur_amp;
		end
		else
		begin
			sample = cur_amp;
		end
		assert (cyc < HIST_LEN)
			else fail_run("stimulus history is full, the entry ran far longer than expected");
		adc_hist[cyc] = sample;
		adc_data_i    = sample[rx_pkg::ADC_BITS-1:0];
		cmd_wr_i      = wr;
		cmd_op_i      = op;
		cmd_data_i    = data;
		rd_samp_i     = rd;
		srq_ack_i     = ack;
		@(posedge cpu_clk);
		#1;
		cyc = cyc + 1;
	endtask

	task automatic idle_cycle();
		tick(1'b0, 2'd0, '0, 1'b0, 1'b0);
	endtask

	task automatic send_cmd(input logic [1:0] op, input logic [31:0] data);
		tick(1'b1, op, data, 1'b0, 1'b0);
	endtask

	task automatic apply_reset();
		rst_i = 1'b1;
		repeat (RESET_CYCLES) idle_cycle();
		rst_i = 1'b0;
	endtask

	// nsamps first, then every channel in order, one command per cycle
	// channel 0 is written well inside its first set, so no set is counted before it
	task automatic configure(input stim_t ent);
		int c;
		send_cmd(rx_pkg::OP_SET_NSAMPS, 32'(ent.nsamps));
		for (c = 0; c < TB_CHANS; c++)
		begin
			send_cmd(rx_pkg::OP_SET_CHAN, 32'(c));
			send_cmd(rx_pkg::OP_SET_FREQ, ent.tune[c]);
			// the write took effect on the edge just passed
			wr_edge[c] = cyc;
		end
	endtask

	task automatic wait_srq(output int rise_cyc);
		while (srq_o !== 1'b1)
		begin
			idle_cycle();
		end
		rise_cyc = cyc;
	endtask

	// reads one bank from word 0 on, acking on the first word
	// words come as ch0 I, ch0 Q, ch1 I and so on, one sample set after another
	task automatic read_bank(input stim_t ent, input int e, input int first_set);
		int          n_words;
		int          w;
		int          s;
		int          c;
		bit          q;
		logic [15:0] exp;
		n_words = 2 * TB_CHANS * (ent.nsamps + 1);
		for (w = 0; w < n_words; w++)
		begin
			s   = first_set + w / (2 * TB_CHANS);
			c   = (w % (2 * TB_CHANS)) / 2;
			q   = (w % 2) == 1;
			exp = expect_word(wr_edge[c], ent.tune[c], s, q);
			assert (samp_o === exp)
				else fail_run($sformatf("Mismatch at %0t: entry %0d set %0d chan %0d %s got %h expected %h",
					$time, e, s, c, q ? "Q" : "I", samp_o, exp));
			// hand-computed words for the constant entries guard the model itself
			if (ent.chk && c == 0)
			begin
				assert (samp_o === (q ? ent.exp_q0 : ent.exp_i0))
					else fail_run($sformatf("Mismatch at %0t: entry %0d chan 0 %s got %h table %h",
						$time, e, q ? "Q" : "I", samp_o, q ? ent.exp_q0 : ent.exp_i0));
			end
			if (w == 0)
			begin
				assert (srq_o === 1'b1)
					else fail_run($sformatf("Mismatch at %0t: entry %0d srq low at bank start",
						$time, e));
			end
			else
			begin
				assert (srq_o === 1'b0)
					else fail_run($sformatf("Mismatch at %0t: entry %0d srq still high after ack",
						$time, e));
			end
			tick(1'b0, 2'd0, '0, w < n_words - 1, w == 0);
		end
	endtask

	task automatic run_entry(input int e);
		stim_t ent;
		int    rise_a;
		int    rise_b;
		int    period;
		ent     = stim_tab[e];
		cur_rnd = ent.rnd;
		cur_amp = int'($signed(ent.amp));
		cyc     = 0;
		apply_reset();
		assert (srq_o === 1'b0)
			else fail_run($sformatf("Mismatch at %0t: entry %0d srq high after reset", $time, e));
		configure(ent);
		period = (ent.nsamps + 1) * TB_DECIM;
		wait_srq(rise_a);
		assert (rise_a - wr_edge[0] >= period)
			else fail_run($sformatf("Mismatch at %0t: entry %0d first swap after %0d cycles, min %0d",
				$time, e, rise_a - wr_edge[0], period));
		read_bank(ent, e, 0);
		// the next bank holds the following nsamps + 1 sets and starts again at word 0
		wait_srq(rise_b);
		assert (rise_b - rise_a == period)
			else fail_run($sformatf("Mismatch at %0t: entry %0d swap period %0d expected %0d",
				$time, e, rise_b - rise_a, period));
		read_bank(ent, e, ent.nsamps + 1);
	endtask

	task automatic load_table();
		// DC at zero frequency, I is DECIM times the scaled product and Q is zero
		stim_tab[0] = '{tune: {32'h0, 32'h0, 32'h0, 32'h0}, rnd: 1'b0, amp: 16'sd1000,
			nsamps: 7'd0, chk: 1'b1, exp_i0: 16'h3e70, exp_q0: 16'h0000};
		stim_tab[1] = '{tune: {32'h0, 32'h0, 32'h0, 32'h0}, rnd: 1'b0, amp: -16'sd1500,
			nsamps: 7'd1, chk: 1'b1, exp_i0: 16'ha240, exp_q0: 16'h0000};
		// quarter rate, the amplitude scales without rounding so both sums cancel
		stim_tab[2] = '{tune: {32'h4000_0000, 32'h4000_0000, 32'h4000_0000, 32'h4000_0000},
			rnd: 1'b0, amp: 16'sd4096, nsamps: 7'd1, chk: 1'b1, exp_i0: 16'h0000,
			exp_q0: 16'h0000};
		// every channel on its own frequency
		stim_tab[3] = '{tune: {32'h2000_0000, 32'h8000_0000, 32'h4000_0000, 32'h0},
			rnd: 1'b0, amp: 16'sd2048, nsamps: 7'd2, chk: 1'b1, exp_i0: 16'h7ff0,
			exp_q0: 16'h0000};
		// random input, checked only against the model
		stim_tab[4] = '{tune: {32'h6000_0000, 32'hc000_0000, 32'h0800_0000, 32'h1234_5678},
			rnd: 1'b1, amp: 16'sd8000, nsamps: 7'd3, chk: 1'b0, exp_i0: 16'h0000,
			exp_q0: 16'h0000};
	endtask

	// an entry needs a reset, the setup and two banks of reads
	function automatic longint run_limit_ns();
		longint cycles;
		int     e;
		cycles = 0;
		for (e = 0; e < NUM_ENTRIES; e++)
		begin
			cycles = cycles + RESET_CYCLES + 4 * (stim_tab[e].nsamps + 2) * (TB_DECIM + 4);
		end
		return cycles * 10 + 1000;
	endfunction

	initial
	begin
		int e;
		rst_i      = 1'b1;
		adc_data_i = '0;
		cmd_wr_i   = 1'b0;
		cmd_op_i   = 2'd0;
		cmd_data_i = '0;
		rd_samp_i  = 1'b0;
		srq_ack_i  = 1'b0;
		seed       = 32'h250a_c0d9;
		cyc        = 0;
		cur_rnd    = 1'b0;
		cur_amp    = 0;
		limit_ns   = 0;
		load_table();
		limit_ns = run_limit_ns();
		for (e = 0; e < NUM_ENTRIES; e++)
		begin
			run_entry(e);
		end
		$display("TB PASSED");
		$finish;
	end

	// watchdog, armed once the table length is known
	initial
	begin
		wait (limit_ns != 0);
		#(limit_ns);
		fail_run($sformatf("watchdog timeout: the run did not finish within %0d ns", limit_ns));
	end

endmodule

// File: project.f
+incdir+tests
hdl/rx_pkg.sv
hdl/rx_cmd_regs.sv
hdl/rx_ddc_chan.sv
hdl/rx_collector.sv
hdl/rx_sample_buf.sv
hdl/rx_receiver.sv
tests/tb_rx_receiver.sv
